// File: design/uartPkg.sv
////////////////////////////////////////
// uart rx shared definitions
// frame, tick and fifo sizes plus the common types
////////////////////////////////////////

package uartPkg;

	////////////////////////////////////////
	// frame and timing
	////////////////////////////////////////

	localparam int dataBits      = 8;   // data bits per frame
	localparam int sbTicks       = 16;  // one stop bit
	localparam int ticksPerBit   = 16;  // oversampling rate
	localparam int clocksPerTick = 4;   // 64 clk per bit

	////////////////////////////////////////
	// receive fifo
	////////////////////////////////////////

	localparam int fifoDepth      = 16;
	localparam int fifoCountWidth = 5;  // holds 0..16

	typedef logic [dataBits-1:0] dataByte_t;  // one received byte

	// status byte: bit0 rxReady, bit1 full, bit2 overrun, rest zero
	typedef logic [7:0] status_t;

	// receiver fsm
	typedef enum logic [1:0]
	{
		stIdle,
		stStart,
		stData,
		stStop
	} rxState_t;

	// host read opcodes, as used by UARTrd and UARTstat
	typedef enum logic
	{
		opReadData,
		opReadStatus
	} hostOp_t;

endpackage

// File: design/baudTickGen.sv
////////////////////////////////////////
// sample tick generator
// one-cycle tick at 16x the bit rate
////////////////////////////////////////

module baudTickGen
(
	input  logic clk,
	input  logic reset,
	output logic sTick
);
	import uartPkg::*;

	logic [1:0] divCnt;  // counts 0..clocksPerTick-1

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divCnt <= '0;
		end
		else if (divCnt == 2'(clocksPerTick - 1))
		begin
			divCnt <= '0;  // wrap
		end
		else
		begin
			divCnt <= divCnt + 2'd1;
		end
	end

	// tick on the last count of each period
	assign sTick = (divCnt == 2'(clocksPerTick - 1));

endmodule

// File: design/uartRec.sv
////////////////////////////////////////
// uart receiver
// oversamples rx, assembles lsb-first bytes
////////////////////////////////////////

module uartRec
(
	input  logic               clk,
	input  logic               reset,
	input  logic               sTick,
	input  logic               rx,
	output logic               rxDoneTick,
	output uartPkg::dataByte_t dOut
);
	import uartPkg::*;

	rxState_t  stateReg;
	rxState_t  stateNext;
	logic [3:0] sReg;    // sample tick counter
	logic [3:0] sNext;
	logic [2:0] nReg;    // data bit counter
	logic [2:0] nNext;
	dataByte_t bReg;     // shift register, fills from the top
	dataByte_t bNext;
	dataByte_t dOutReg;  // last complete byte

	////////////////////////////////////////
	// state registers
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= stIdle;
			sReg     <= '0;
			nReg     <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
		end
	end

	always_ff @(posedge clk)
	begin
		bReg <= bNext;
		// capture once the last data bit is in, holds through the next frame
		if (stateReg == stData && stateNext == stStop)
			dOutReg <= bNext;
	end

	////////////////////////////////////////
	// next state logic
	////////////////////////////////////////

	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		rxDoneTick = 1'b0;
		case (stateReg)
			stIdle:
				if (!rx)  // falling edge of the start bit
				begin
					stateNext = stStart;
					sNext     = '0;
				end
			stStart:
				if (sTick)
				begin
					if (sReg == 4'(ticksPerBit / 2 - 1))  // middle of start bit
					begin
						stateNext = stData;
						sNext     = '0;
						nNext     = '0;
					end
					else
						sNext = sReg + 4'd1;
				end
			stData:
				if (sTick)
				begin
					if (sReg == 4'(ticksPerBit - 1))  // middle of a data bit
					begin
						sNext = '0;
						bNext = {rx, bReg[dataBits-1:1]};  // lsb arrives first
						if (nReg == 3'(dataBits - 1))
							stateNext = stStop;
						else
							nNext = nReg + 3'd1;
					end
					else
						sNext = sReg + 4'd1;
				end
			stStop:
				if (sTick)
				begin
					if (sReg == 4'(sbTicks - 1))  // stop level not checked
					begin
						stateNext  = stIdle;
						rxDoneTick = 1'b1;
					end
					else
						sNext = sReg + 4'd1;
				end
			default:
				stateNext = stIdle;
		endcase
	end

	assign dOut = dOutReg;

	// done pulse on a stop tick, assembled byte already on dOut
	assert property (@(posedge clk) disable iff (reset)
		rxDoneTick |-> (stateReg == stStop && sTick && dOut == bReg));

	// bit counter stops at the last bit, never past it
	assert property (@(posedge clk) disable iff (reset)
		(stateReg == stStop) |-> (nReg == 3'(dataBits - 1)));

endmodule

// File: design/rxFifo.sv
////////////////////////////////////////
// receive byte fifo
// 16-deep ring buffer, sticky overrun
////////////////////////////////////////

module rxFifo
(
	input  logic               clk,
	input  logic               reset,
	input  logic               wrEn,
	input  uartPkg::dataByte_t wrData,
	input  logic               pop,
	input  logic               clearOverrun,
	output uartPkg::dataByte_t rdData,
	output logic               empty,
	output logic               full,
	output logic               overrun
);
	import uartPkg::*;

	dataByte_t mem [fifoDepth];
	logic [fifoCountWidth-2:0] wrPtr;  // wraps at fifoDepth
	logic [fifoCountWidth-2:0] rdPtr;
	logic [fifoCountWidth-1:0] count;
	logic doPush;
	logic doPop;

	assign doPush = wrEn && !full;   // byte dropped when full
	assign doPop  = pop && !empty;

	////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= wrData;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			count   <= '0;
			overrun <= 1'b0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
			// a new loss wins over a clear in the same cycle
			if (wrEn && full)
				overrun <= 1'b1;
			else if (clearOverrun)
				overrun <= 1'b0;
		end
	end

	assign rdData = mem[rdPtr];  // head always visible
	assign empty  = (count == '0);
	assign full   = (count == fifoCountWidth'(fifoDepth));

	// host port must not pop an empty fifo
	assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

	assert property (@(posedge clk) disable iff (reset)
		count <= fifoCountWidth'(fifoDepth));

endmodule

// File: design/hostReadPort.sv
////////////////////////////////////////
// host read port
// four-phase req/ack for data and status reads
////////////////////////////////////////

module hostReadPort
(
	input  logic               clk,
	input  logic               reset,
	input  logic               req,
	input  uartPkg::hostOp_t   op,
	output logic               ack,
	output uartPkg::dataByte_t rdata,
	input  uartPkg::dataByte_t fifoData,
	input  logic               empty,
	input  logic               full,
	input  logic               overrun,
	output logic               pop,
	output logic               clearOverrun
);
	import uartPkg::*;

	typedef enum logic
	{
		portIdle,
		portAck
	} portState_t;

	portState_t stateReg;
	logic       accept;      // request taken this cycle
	status_t    statusByte;

	assign accept       = (stateReg == portIdle) && req;
	assign pop          = accept && (op == opReadData) && !empty;
	assign clearOverrun = accept && (op == opReadStatus);
	assign statusByte   = {5'b0, overrun, full, !empty};  // flags before the request
	assign ack          = (stateReg == portAck);

	////////////////////////////////////////
	// handshake
	////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= portIdle;
		end
		else
		begin
			case (stateReg)
				portIdle: if (req) stateReg <= portAck;
				portAck:  if (!req) stateReg <= portIdle;  // hold ack while req high
				default:  stateReg <= portIdle;
			endcase
		end
	end

	// read data, latched with the accept edge
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			if (op == opReadStatus)
				rdata <= statusByte;
			else
				rdata <= empty ? '0 : fifoData;  // empty read returns 0
		end
	end

	assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> $past(req));

	// one pop per handshake
	assert property (@(posedge clk) disable iff (reset) pop |=> (ack && !pop));

endmodule

// File: design/uartRxTop.sv
////////////////////////////////////////
// uart receive path top
// tick gen, receiver, fifo and host port
////////////////////////////////////////

module uartRxTop
(
	input  logic               clk,
	input  logic               reset,
	input  logic               rx,
	input  logic               req,
	input  uartPkg::hostOp_t   op,
	output logic               ack,
	output uartPkg::dataByte_t rdata
);
	import uartPkg::*;

	logic      sTick;
	logic      rxDoneTick;
	dataByte_t rxByte;        // receiver to fifo
	dataByte_t fifoData;      // fifo head
	logic      empty;
	logic      full;
	logic      overrun;
	logic      pop;
	logic      clearOverrun;

	baudTickGen baudTickGen_i (.clk(clk), .reset(reset), .sTick(sTick));

	uartRec uartRec_i (.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxDoneTick(rxDoneTick), .dOut(rxByte));

	rxFifo rxFifo_i (.clk(clk), .reset(reset), .wrEn(rxDoneTick), .wrData(rxByte),
		.pop(pop), .clearOverrun(clearOverrun), .rdData(fifoData),
		.empty(empty), .full(full), .overrun(overrun));

	hostReadPort hostReadPort_i (.clk(clk), .reset(reset), .req(req), .op(op),
		.ack(ack), .rdata(rdata), .fifoData(fifoData), .empty(empty), .full(full),
		.overrun(overrun), .pop(pop), .clearOverrun(clearOverrun));

endmodule

// File: verification/clockGen.sv
////////////////////////////////////////
// testbench clock and reset
// 8 ns clock, reset held for 16 cycles
////////////////////////////////////////

module clockGen
(
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk   = 1'b0;
		reset = 1'b1;
		forever #4 clk = ~clk;  // 8 ns period
	end

	initial
	begin
		repeat (16) @(posedge clk);
		@(negedge clk);  // release away from the active edge
		reset = 1'b0;
	end

endmodule

// File: verification/uartRxTb.sv
////////////////////////////////////////
// uart receive path testbench
// golden file driven sends and host reads
////////////////////////////////////////

module uartRxTb;
	timeunit 1ns;
	timeprecision 100ps;

	import uartPkg::*;

	localparam int bitClocks      = ticksPerBit * clocksPerTick;  // 64 clk per bit
	localparam int clkPeriodNs    = 8;
	localparam int handshakeLimit = 32;  // cycles to wait for ack edges

	logic      clk;
	logic      reset;
	logic      rx;
	logic      req;
	hostOp_t   op;
	logic      ack;
	dataByte_t rdata;

	byte       cmdQ[$];  // command letter
	int        valQ[$];  // first byte or expected status
	int        cntQ[$];  // repeat count
	logic      goldenLoaded = 1'b0;
	logic      aborted = 1'b0;
	string     abortWhy;
	longint    watchdogNs;
	int        passCount = 0;
	int        failCount = 0;

	clockGen clockGen_i (.clk(clk), .reset(reset));

	uartRxTop dut_i (.clk(clk), .reset(reset), .rx(rx), .req(req), .op(op),
		.ack(ack), .rdata(rdata));

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// flag a fatal error for the abort process
	task automatic abortRun(input string why);
		abortWhy = why;
		aborted  = 1'b1;
	endtask

	task automatic loadGolden();
		int    fd;
		int    n;
		byte   cmd;
		int    val;
		int    cnt;
		string line;
		fd = $fopen("verification/uartRx_golden.txt", "r");
		if (fd == 0)
			abortRun("cannot open verification/uartRx_golden.txt");
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 5 || line[0] == "#")  // blank or comment
					continue;
				n = $sscanf(line, "%c %h %d", cmd, val, cnt);
				if (n != 3)
				begin
					failCount++;
					$display("golden line could not be parsed: %s", line);
					continue;
				end
				cmdQ.push_back(cmd);
				valQ.push_back(val);
				cntQ.push_back(cnt);
			end
			$fclose(fd);
		end
	endtask

	// one bit time on rx, changed on the falling edge
	task automatic driveBit(input logic level);
		@(negedge clk);
		rx = level;
		repeat (bitClocks - 1) @(negedge clk);
	endtask

	task automatic sendByte(input dataByte_t value);
		int gap;
		driveBit(1'b0);                    // start
		for (int i = 0; i < dataBits; i++)
			driveBit(value[i]);            // lsb first
		driveBit(1'b1);                    // stop
		gap = $urandom_range(3, 1);        // idle between frames
		repeat (gap) driveBit(1'b1);
	endtask

	// four-phase read, sampled on falling edges
	task automatic hostRead(input hostOp_t opSel, output dataByte_t value);
		int waitCnt;
		@(negedge clk);
		req = 1'b1;
		op  = opSel;
		waitCnt = 0;
		while (!ack)
		begin
			@(negedge clk);
			waitCnt++;
			if (waitCnt > handshakeLimit)
				abortRun("host port never raised ack");
		end
		value = rdata;
		req   = 1'b0;
		waitCnt = 0;
		while (ack)
		begin
			@(negedge clk);
			waitCnt++;
			if (waitCnt > handshakeLimit)
				abortRun("host port kept ack high after req dropped");
		end
	endtask

	task automatic compareData(input dataByte_t got, input dataByte_t exp);
		if (got === exp)
		begin
			passCount++;
			$display("ok     data read    rdata 0x%h", got);
		end
		else
		begin
			failCount++;
			$display("[FAIL] rdata got 0x%h expected 0x%h", got, exp);
		end
	endtask

	task automatic compareStatus(input status_t got, input status_t exp);
		if (got === exp)
		begin
			passCount++;
			$display("ok     status read  status 0x%h", got);
		end
		else
		begin
			failCount++;
			$display("[FAIL] status got 0x%h expected 0x%h", got, exp);
		end
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		longint    total;
		dataByte_t got;
		rx  = 1'b1;  // idle line
		req = 1'b0;
		op  = opReadData;
		void'($urandom(32'hc905));
		loadGolden();
		total = 0;
		foreach (cntQ[k])
			total += cntQ[k];
		// 12 bit times per command plus the reset
		watchdogNs   = total * 12 * bitClocks * clkPeriodNs + 32 * clkPeriodNs;
		goldenLoaded = 1'b1;
		wait (!reset);
		@(negedge clk);
		foreach (cmdQ[k])
		begin
			case (cmdQ[k])
				"S":
					for (int i = 0; i < cntQ[k]; i++)
						sendByte(dataByte_t'(valQ[k] + i));
				"D":
					for (int i = 0; i < cntQ[k]; i++)
					begin
						hostRead(opReadData, got);
						compareData(got, dataByte_t'(valQ[k] + i));  // byte i of the run
					end
				"T":
					for (int i = 0; i < cntQ[k]; i++)
					begin
						hostRead(opReadStatus, got);
						compareStatus(status_t'(got), status_t'(valQ[k]));
					end
				default:
				begin
					failCount++;
					$display("unknown golden command %c", cmdQ[k]);
				end
			endcase
		end
		$display("tests %0d  passed %0d  failed %0d", passCount + failCount,
			passCount, failCount);
		if (failCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// abort on a missing golden file or a stuck handshake
	initial
	begin
		wait (aborted);
		$display("error: %s", abortWhy);
		$display("=== FAIL ===");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (goldenLoaded);
		#(watchdogNs);
		$display("watchdog expired after %0d ns, the run did not complete", watchdogNs);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verification/uartRx_golden.txt
# cmd value count: S sends count bytes value, value+1, ... on rx
# D reads count bytes expecting value, value+1, ...; T reads status count times expecting value
# after reset
T 00 1
D 00 1
T 00 1
# single byte
S 3c 1
T 01 1
D 3c 1
T 00 1
# fifo order and lsb-first assembly
S 00 1
S ff 1
S a5 1
S 5a 1
D 00 1
D ff 1
D a5 1
D 5a 1
T 00 1
# seventeen bytes, the last one is dropped
S 30 17
T 07 1
T 03 1
D 30 16
T 00 1

// File: all.f
design/uartPkg.sv
design/baudTickGen.sv
design/uartRec.sv
design/rxFifo.sv
design/hostReadPort.sv
design/uartRxTop.sv
verification/clockGen.sv
verification/uartRxTb.sv

// File: run.sh
#!/bin/sh
# build the uart receive testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module uartRxTb -f all.f -o simUartRx

status=0
./obj_dir/simUartRx > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "=== PASS ===" sim.log; then
	exit 0
fi
exit 1
